// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    // Major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL functs
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // REGIMM codes in the rt field
    localparam logic [4:0] RI_BLTZ   = 5'b00000;
    localparam logic [4:0] RI_BGEZ   = 5'b00001;
    localparam logic [4:0] RI_BLTZAL = 5'b10000;
    localparam logic [4:0] RI_BGEZAL = 5'b10001;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
    } instr_word_u;

endpackage

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

    localparam int NUM_STAGES = 3;  // E, M, W
    localparam int CTRL_W     = 30; // Top bit spare

    // Control-word field low bits and wide-field widths
    localparam int CF_ALU_SRCB_SEL_RT  = 0;
    localparam int CF_SFT_SRCB_SEL_RS  = 1;
    localparam int CF_SFT_SRCA_SEL_IMM = 2;
    localparam int CF_OUT_SHIFT        = 3;
    localparam int CF_REGWRITE         = 4;
    localparam int CF_REGDST           = 5;
    localparam int CF_REGDST_W         = 2;
    localparam int CF_RESERVED         = 7;
    localparam int CF_LINK             = 8;
    localparam int CF_ISBRANCH         = 9;
    localparam int CF_ISJUMP           = 10;
    localparam int CF_BRANCH           = 11;
    localparam int CF_BRANCH_W         = 3;
    localparam int CF_JUMP             = 14;
    localparam int CF_JUMP_W           = 2;
    localparam int CF_MEMREQ           = 16;
    localparam int CF_MEMWR            = 17;
    localparam int CF_ALU_FUNC         = 18;
    localparam int CF_ALU_FUNC_W       = 3;
    localparam int CF_SFT_FUNC         = 21;
    localparam int CF_SFT_FUNC_W       = 2;
    localparam int CF_INTOVF_EN        = 23;
    localparam int CF_IMM_SIGN         = 24;
    localparam int CF_SIZE             = 25;
    localparam int CF_SIZE_W           = 2;
    localparam int CF_RDATA_SIGN       = 27;
    localparam int CF_MEMTOREG         = 28;

    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_SUB  = 3'd1;
    localparam logic [2:0] ALU_SLT  = 3'd2;
    localparam logic [2:0] ALU_SLTU = 3'd3;
    localparam logic [2:0] ALU_AND  = 3'd4;
    localparam logic [2:0] ALU_NOR  = 3'd5;
    localparam logic [2:0] ALU_OR   = 3'd6;
    localparam logic [2:0] ALU_XOR  = 3'd7;

    localparam logic [1:0] SFT_LUI = 2'd0;
    localparam logic [1:0] SFT_SLL = 2'd1;
    localparam logic [1:0] SFT_SRA = 2'd2;
    localparam logic [1:0] SFT_SRL = 2'd3;

    localparam logic [2:0] BR_EQ    = 3'd0;
    localparam logic [2:0] BR_NE    = 3'd1;
    localparam logic [2:0] BR_GEZ   = 3'd2;
    localparam logic [2:0] BR_GTZ   = 3'd3;
    localparam logic [2:0] BR_LEZ   = 3'd4;
    localparam logic [2:0] BR_LTZ   = 3'd5;
    localparam logic [2:0] BR_GEZAL = 3'd6;
    localparam logic [2:0] BR_LTZAL = 3'd7;

    localparam logic [1:0] JMP_J    = 2'd0;
    localparam logic [1:0] JMP_JR   = 2'd1;
    localparam logic [1:0] JMP_JAL  = 2'd2;
    localparam logic [1:0] JMP_JALR = 2'd3;

    localparam logic [1:0] REGDST_RT = 2'd0;
    localparam logic [1:0] REGDST_RD = 2'd1;
    localparam logic [1:0] REGDST_RA = 2'd2;

    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

endpackage

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import mips_isa_pkg::*, ctrl_pkg::*; (
    input  instr_word_u       dinstr,
    output logic [CTRL_W-1:0] d_ctrl
);

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] ri_code;
    logic [2:0] alu_r;
    logic [2:0] alu_i;
    logic [1:0] sft_r;
    logic [2:0] br_code;
    logic [1:0] mem_size;

    assign op      = dinstr.i_fmt.op;
    assign funct   = dinstr.r_fmt.funct;
    assign ri_code = dinstr.i_fmt.rt; // REGIMM code sits in rt

    always_comb
    begin
        case (funct)
            FN_SUB, FN_SUBU: alu_r = ALU_SUB;
            FN_SLT:          alu_r = ALU_SLT;
            FN_SLTU:         alu_r = ALU_SLTU;
            FN_AND:          alu_r = ALU_AND;
            FN_NOR:          alu_r = ALU_NOR;
            FN_OR:           alu_r = ALU_OR;
            FN_XOR:          alu_r = ALU_XOR;
            default:         alu_r = ALU_ADD;
        endcase
        case (op)
            OP_SLTI:  alu_i = ALU_SLT;
            OP_SLTIU: alu_i = ALU_SLTU;
            OP_ANDI:  alu_i = ALU_AND;
            OP_ORI:   alu_i = ALU_OR;
            OP_XORI:  alu_i = ALU_XOR;
            default:  alu_i = ALU_ADD; // Also address add for loads and stores
        endcase
        case (funct)
            FN_SRA, FN_SRAV: sft_r = SFT_SRA;
            FN_SRL, FN_SRLV: sft_r = SFT_SRL;
            default:         sft_r = SFT_SLL;
        endcase
        case (op)
            OP_LH, OP_LHU, OP_SH: mem_size = SIZE_H;
            OP_LW, OP_SW:         mem_size = SIZE_W;
            default:              mem_size = SIZE_B;
        endcase
    end

    always_comb
    begin
        case (op)
            OP_BNE:  br_code = BR_NE;
            OP_BGTZ: br_code = BR_GTZ;
            OP_BLEZ: br_code = BR_LEZ;
            OP_REGIMM:
            begin
                case (ri_code)
                    RI_BGEZ:   br_code = BR_GEZ;
                    RI_BLTZAL: br_code = BR_LTZAL;
                    RI_BGEZAL: br_code = BR_GEZAL;
                    default:   br_code = BR_LTZ;
                endcase
            end
            default: br_code = BR_EQ;
        endcase
    end

    always_comb
    begin
        d_ctrl = '0;
        unique case (op)
            OP_SPECIAL:
            begin
                case (funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR:
                    begin
                        d_ctrl[CF_ALU_SRCB_SEL_RT] = 1'b1;
                        d_ctrl[CF_REGWRITE] = 1'b1;
                        d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RD;
                        d_ctrl[CF_ALU_FUNC +: CF_ALU_FUNC_W] = alu_r;
                        d_ctrl[CF_INTOVF_EN] = (funct == FN_ADD) || (funct == FN_SUB);
                    end
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
                    begin
                        d_ctrl[CF_OUT_SHIFT] = 1'b1;
                        d_ctrl[CF_REGWRITE] = 1'b1;
                        d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RD;
                        d_ctrl[CF_SFT_FUNC +: CF_SFT_FUNC_W] = sft_r;
                        d_ctrl[CF_SFT_SRCB_SEL_RS] = funct[2]; // V forms have bit 2 set
                    end
                    FN_JR:
                    begin
                        d_ctrl[CF_ISJUMP] = 1'b1;
                        d_ctrl[CF_JUMP +: CF_JUMP_W] = JMP_JR;
                    end
                    FN_JALR:
                    begin
                        d_ctrl[CF_ISJUMP] = 1'b1;
                        d_ctrl[CF_JUMP +: CF_JUMP_W] = JMP_JALR;
                        d_ctrl[CF_LINK] = 1'b1;
                        d_ctrl[CF_REGWRITE] = 1'b1;
                        d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RD;
                    end
                    default: d_ctrl[CF_RESERVED] = 1'b1;
                endcase
            end
            OP_REGIMM:
            begin
                if (ri_code inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL})
                begin
                    d_ctrl[CF_ISBRANCH] = 1'b1;
                    d_ctrl[CF_BRANCH +: CF_BRANCH_W] = br_code;
                    if (ri_code[4]) // AL forms write ra
                    begin
                        d_ctrl[CF_LINK] = 1'b1;
                        d_ctrl[CF_REGWRITE] = 1'b1;
                        d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RA;
                    end
                end
                else
                begin
                    d_ctrl[CF_RESERVED] = 1'b1;
                end
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ:
            begin
                d_ctrl[CF_ISBRANCH] = 1'b1;
                d_ctrl[CF_BRANCH +: CF_BRANCH_W] = br_code;
            end
            OP_J:
            begin
                d_ctrl[CF_ISJUMP] = 1'b1;
                d_ctrl[CF_JUMP +: CF_JUMP_W] = JMP_J;
            end
            OP_JAL:
            begin
                d_ctrl[CF_ISJUMP] = 1'b1;
                d_ctrl[CF_JUMP +: CF_JUMP_W] = JMP_JAL;
                d_ctrl[CF_LINK] = 1'b1;
                d_ctrl[CF_REGWRITE] = 1'b1;
                d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RA;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
            begin
                d_ctrl[CF_REGWRITE] = 1'b1;
                d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RT;
                d_ctrl[CF_ALU_FUNC +: CF_ALU_FUNC_W] = alu_i;
                d_ctrl[CF_IMM_SIGN] = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
                d_ctrl[CF_INTOVF_EN] = (op == OP_ADDI);
            end
            OP_LUI:
            begin
                d_ctrl[CF_OUT_SHIFT] = 1'b1;
                d_ctrl[CF_SFT_SRCA_SEL_IMM] = 1'b1;
                d_ctrl[CF_SFT_FUNC +: CF_SFT_FUNC_W] = SFT_LUI;
                d_ctrl[CF_REGWRITE] = 1'b1;
                d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RT;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW:
            begin
                d_ctrl[CF_MEMREQ] = 1'b1;
                d_ctrl[CF_IMM_SIGN] = 1'b1;
                d_ctrl[CF_ALU_FUNC +: CF_ALU_FUNC_W] = alu_i;
                d_ctrl[CF_SIZE +: CF_SIZE_W] = mem_size;
                d_ctrl[CF_MEMWR] = op[3]; // Stores
                d_ctrl[CF_REGWRITE] = !op[3];
                d_ctrl[CF_REGDST +: CF_REGDST_W] = REGDST_RT;
                d_ctrl[CF_MEMTOREG] = !op[3];
                d_ctrl[CF_RDATA_SIGN] = op inside {OP_LB, OP_LH, OP_LW};
            end
            default: d_ctrl[CF_RESERVED] = 1'b1;
        endcase
    end

    a_store_is_mem: assert final ($isunknown(dinstr) || !d_ctrl[CF_MEMWR] || d_ctrl[CF_MEMREQ])
        else $error("memwr set without memreq");
    a_branch_xor_jump: assert final ($isunknown(dinstr)
                                     || !(d_ctrl[CF_ISBRANCH] && d_ctrl[CF_ISJUMP]))
        else $error("isbranch and isjump both set");

endmodule

// File: hdl/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver import ctrl_pkg::*; (
    input  logic       isbranch,
    input  logic [2:0] branch,
    input  logic       cmp_equal,
    input  logic       cmp_g0,
    input  logic       cmp_e0,
    output logic       pcsrc
);

    logic [7:0] cond; // Indexed by branch code

    assign cond[BR_EQ]    = cmp_equal;
    assign cond[BR_NE]    = !cmp_equal;
    assign cond[BR_GEZ]   = cmp_g0 || cmp_e0;
    assign cond[BR_GTZ]   = cmp_g0;
    assign cond[BR_LEZ]   = !cmp_g0;
    assign cond[BR_LTZ]   = !cmp_g0 && !cmp_e0;
    assign cond[BR_GEZAL] = cmp_g0 || cmp_e0;
    assign cond[BR_LTZAL] = !cmp_g0 && !cmp_e0;

    assign pcsrc = isbranch && cond[branch];

    a_taken_is_branch: assert final ($isunknown({isbranch, branch}) || !pcsrc || isbranch)
        else $error("pcsrc raised for a non-branch");

endmodule

// File: hdl/ctrl_stage_reg.sv
`timescale 1ns/1ps

module ctrl_stage_reg import ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              stall,
    input  logic [CTRL_W-1:0] ctrl_in,
    output logic [CTRL_W-1:0] ctrl_out
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl_out <= '0;
        end
        else if (flush) // Wins over stall
        begin
            ctrl_out <= '0;
        end
        else if (!stall)
        begin
            ctrl_out <= ctrl_in;
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
                                     flush |=> (ctrl_out == '0))
        else $error("stage not cleared after flush");

endmodule

// File: hdl/controller.sv
`timescale 1ns/1ps

module controller import mips_isa_pkg::*, ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  instr_word_u           dinstr,
    input  logic [NUM_STAGES-1:0] flush,
    input  logic [NUM_STAGES-1:0] stall,
    input  logic                  cmp_equal,
    input  logic                  cmp_g0,
    input  logic                  cmp_e0,
    output logic [CTRL_W-1:0]     d_ctrl,
    output logic                  pcsrc,
    output logic [CTRL_W-1:0]     e_ctrl,
    output logic [CTRL_W-1:0]     m_ctrl,
    output logic [CTRL_W-1:0]     w_ctrl
);

    logic [CTRL_W-1:0] chain [0:NUM_STAGES]; // Entry 0 is decode

    instr_decoder u_decoder (
        .dinstr (dinstr),
        .d_ctrl (d_ctrl)
    );

    branch_resolver u_resolver (
        .isbranch  (d_ctrl[CF_ISBRANCH]),
        .branch    (d_ctrl[CF_BRANCH +: CF_BRANCH_W]),
        .cmp_equal (cmp_equal),
        .cmp_g0    (cmp_g0),
        .cmp_e0    (cmp_e0),
        .pcsrc     (pcsrc)
    );

    assign chain[0] = d_ctrl;

    for (genvar i = 0; i < NUM_STAGES; i++)
    begin : g_stage
        ctrl_stage_reg u_reg (
            .clk      (clk),
            .rst_n    (rst_n),
            .flush    (flush[i]),
            .stall    (stall[i]),
            .ctrl_in  (chain[i]),
            .ctrl_out (chain[i+1])
        );
    end

    assign e_ctrl = chain[1];
    assign m_ctrl = chain[2];
    assign w_ctrl = chain[3];

endmodule

// File: tests/controller_tb.sv
`timescale 1ns/1ps

module controller_tb import mips_isa_pkg::*, ctrl_pkg::*; ();

    localparam int NUM_TESTS  = 48;
    localparam int MAX_CYCLES = 20 + 4 * NUM_TESTS + 40;

    logic                  clk;
    logic                  rst_n;
    instr_word_u           dinstr;
    logic [NUM_STAGES-1:0] flush;
    logic [NUM_STAGES-1:0] stall;
    logic                  cmp_equal;
    logic                  cmp_g0;
    logic                  cmp_e0;
    logic [CTRL_W-1:0]     d_ctrl;
    logic                  pcsrc;
    logic [CTRL_W-1:0]     e_ctrl;
    logic [CTRL_W-1:0]     m_ctrl;
    logic [CTRL_W-1:0]     w_ctrl;

    string             tname  [NUM_TESTS];
    logic [31:0]       tinstr [NUM_TESTS];
    logic [2:0]        tflags [NUM_TESTS]; // {equal, g0, e0}
    logic [CTRL_W-1:0] tctrl  [NUM_TESTS];
    logic              tpc    [NUM_TESTS];
    int                n_entries = 0;
    integer            seed;
    int                cycles = 0;
    int                test_errs = 0;
    int                pass_count = 0;
    int                fail_count = 0;

    controller dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dinstr    (dinstr),
        .flush     (flush),
        .stall     (stall),
        .cmp_equal (cmp_equal),
        .cmp_g0    (cmp_g0),
        .cmp_e0    (cmp_e0),
        .d_ctrl    (d_ctrl),
        .pcsrc     (pcsrc),
        .e_ctrl    (e_ctrl),
        .m_ctrl    (m_ctrl),
        .w_ctrl    (w_ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Run timed out after %0d cycles before all tests finished", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Places a value at a control-word field
    function automatic logic [CTRL_W-1:0] fld(input int pos, input int unsigned val);
        logic [CTRL_W-1:0] w;
        w = CTRL_W'(val);
        return w << pos;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] funct);
        return {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd4, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op);
        return {op, 5'd1, 5'd2, 16'h1234};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [4:0] code);
        return {OP_REGIMM, 5'd1, code, 16'h0010};
    endfunction

    // Taken rule per branch code
    function automatic logic branch_taken(input logic [2:0] code, input logic [2:0] f);
        case (code)
            BR_EQ:            return f[2];
            BR_NE:            return !f[2];
            BR_GEZ, BR_GEZAL: return f[1] || f[0];
            BR_GTZ:           return f[1];
            BR_LEZ:           return !f[1];
            default:          return !f[1] && !f[0];
        endcase
    endfunction

    task automatic add_entry(input string name, input logic [31:0] instr,
                             input logic [CTRL_W-1:0] exp);
        tname[n_entries]  = name;
        tinstr[n_entries] = instr;
        tflags[n_entries] = 3'($random(seed));
        tctrl[n_entries]  = exp;
        tpc[n_entries]    = exp[CF_ISBRANCH]
                            && branch_taken(exp[CF_BRANCH +: CF_BRANCH_W], tflags[n_entries]);
        n_entries++;
    endtask

    task automatic build_table();
        logic [CTRL_W-1:0] r_alu;
        logic [CTRL_W-1:0] i_alu;
        logic [CTRL_W-1:0] sft;
        logic [CTRL_W-1:0] ld;
        logic [CTRL_W-1:0] st;
        logic [CTRL_W-1:0] lnk;
        logic [CTRL_W-1:0] br;
        logic [CTRL_W-1:0] jmp;
        logic [CTRL_W-1:0] ovf;
        logic [CTRL_W-1:0] imm;
        r_alu = fld(CF_ALU_SRCB_SEL_RT, 1) | fld(CF_REGWRITE, 1) | fld(CF_REGDST, REGDST_RD);
        i_alu = fld(CF_REGWRITE, 1) | fld(CF_REGDST, REGDST_RT);
        sft   = fld(CF_OUT_SHIFT, 1) | fld(CF_REGWRITE, 1) | fld(CF_REGDST, REGDST_RD);
        st    = fld(CF_MEMREQ, 1) | fld(CF_IMM_SIGN, 1) | fld(CF_ALU_FUNC, ALU_ADD);
        ld    = st | fld(CF_REGWRITE, 1) | fld(CF_MEMTOREG, 1) | fld(CF_REGDST, REGDST_RT);
        st    = st | fld(CF_MEMWR, 1);
        lnk   = fld(CF_LINK, 1) | fld(CF_REGWRITE, 1);
        br    = fld(CF_ISBRANCH, 1);
        jmp   = fld(CF_ISJUMP, 1);
        ovf   = fld(CF_INTOVF_EN, 1);
        imm   = fld(CF_IMM_SIGN, 1);
        add_entry("add",    enc_r(FN_ADD),    r_alu | fld(CF_ALU_FUNC, ALU_ADD) | ovf);
        add_entry("addu",   enc_r(FN_ADDU),   r_alu | fld(CF_ALU_FUNC, ALU_ADD));
        add_entry("sub",    enc_r(FN_SUB),    r_alu | fld(CF_ALU_FUNC, ALU_SUB) | ovf);
        add_entry("subu",   enc_r(FN_SUBU),   r_alu | fld(CF_ALU_FUNC, ALU_SUB));
        add_entry("slt",    enc_r(FN_SLT),    r_alu | fld(CF_ALU_FUNC, ALU_SLT));
        add_entry("sltu",   enc_r(FN_SLTU),   r_alu | fld(CF_ALU_FUNC, ALU_SLTU));
        add_entry("and",    enc_r(FN_AND),    r_alu | fld(CF_ALU_FUNC, ALU_AND));
        add_entry("or",     enc_r(FN_OR),     r_alu | fld(CF_ALU_FUNC, ALU_OR));
        add_entry("xor",    enc_r(FN_XOR),    r_alu | fld(CF_ALU_FUNC, ALU_XOR));
        add_entry("nor",    enc_r(FN_NOR),    r_alu | fld(CF_ALU_FUNC, ALU_NOR));
        add_entry("addi",   enc_i(OP_ADDI),   i_alu | fld(CF_ALU_FUNC, ALU_ADD) | imm | ovf);
        add_entry("addiu",  enc_i(OP_ADDIU),  i_alu | fld(CF_ALU_FUNC, ALU_ADD) | imm);
        add_entry("slti",   enc_i(OP_SLTI),   i_alu | fld(CF_ALU_FUNC, ALU_SLT) | imm);
        add_entry("sltiu",  enc_i(OP_SLTIU),  i_alu | fld(CF_ALU_FUNC, ALU_SLTU) | imm);
        add_entry("andi",   enc_i(OP_ANDI),   i_alu | fld(CF_ALU_FUNC, ALU_AND));
        add_entry("ori",    enc_i(OP_ORI),    i_alu | fld(CF_ALU_FUNC, ALU_OR));
        add_entry("xori",   enc_i(OP_XORI),   i_alu | fld(CF_ALU_FUNC, ALU_XOR));
        add_entry("sll",    enc_r(FN_SLL),    sft | fld(CF_SFT_FUNC, SFT_SLL));
        add_entry("srl",    enc_r(FN_SRL),    sft | fld(CF_SFT_FUNC, SFT_SRL));
        add_entry("sra",    enc_r(FN_SRA),    sft | fld(CF_SFT_FUNC, SFT_SRA));
        add_entry("sllv",   enc_r(FN_SLLV),   sft | fld(CF_SFT_FUNC, SFT_SLL)
                                              | fld(CF_SFT_SRCB_SEL_RS, 1));
        add_entry("srlv",   enc_r(FN_SRLV),   sft | fld(CF_SFT_FUNC, SFT_SRL)
                                              | fld(CF_SFT_SRCB_SEL_RS, 1));
        add_entry("srav",   enc_r(FN_SRAV),   sft | fld(CF_SFT_FUNC, SFT_SRA)
                                              | fld(CF_SFT_SRCB_SEL_RS, 1));
        add_entry("lui",    enc_i(OP_LUI),    i_alu | fld(CF_OUT_SHIFT, 1)
                                              | fld(CF_SFT_SRCA_SEL_IMM, 1));
        add_entry("beq",    enc_i(OP_BEQ),    br | fld(CF_BRANCH, BR_EQ));
        add_entry("bne",    enc_i(OP_BNE),    br | fld(CF_BRANCH, BR_NE));
        add_entry("bgtz",   enc_i(OP_BGTZ),   br | fld(CF_BRANCH, BR_GTZ));
        add_entry("blez",   enc_i(OP_BLEZ),   br | fld(CF_BRANCH, BR_LEZ));
        add_entry("bgez",   enc_ri(RI_BGEZ),  br | fld(CF_BRANCH, BR_GEZ));
        add_entry("bltz",   enc_ri(RI_BLTZ),  br | fld(CF_BRANCH, BR_LTZ));
        add_entry("bgezal", enc_ri(RI_BGEZAL), br | fld(CF_BRANCH, BR_GEZAL) | lnk
                                               | fld(CF_REGDST, REGDST_RA));
        add_entry("bltzal", enc_ri(RI_BLTZAL), br | fld(CF_BRANCH, BR_LTZAL) | lnk
                                               | fld(CF_REGDST, REGDST_RA));
        add_entry("j",      enc_i(OP_J),      jmp | fld(CF_JUMP, JMP_J));
        add_entry("jr",     enc_r(FN_JR),     jmp | fld(CF_JUMP, JMP_JR));
        add_entry("jal",    enc_i(OP_JAL),    jmp | fld(CF_JUMP, JMP_JAL) | lnk
                                              | fld(CF_REGDST, REGDST_RA));
        add_entry("jalr",   enc_r(FN_JALR),   jmp | fld(CF_JUMP, JMP_JALR) | lnk
                                              | fld(CF_REGDST, REGDST_RD));
        add_entry("lb",     enc_i(OP_LB),     ld | fld(CF_SIZE, SIZE_B) | fld(CF_RDATA_SIGN, 1));
        add_entry("lbu",    enc_i(OP_LBU),    ld | fld(CF_SIZE, SIZE_B));
        add_entry("lh",     enc_i(OP_LH),     ld | fld(CF_SIZE, SIZE_H) | fld(CF_RDATA_SIGN, 1));
        add_entry("lhu",    enc_i(OP_LHU),    ld | fld(CF_SIZE, SIZE_H));
        add_entry("lw",     enc_i(OP_LW),     ld | fld(CF_SIZE, SIZE_W) | fld(CF_RDATA_SIGN, 1));
        add_entry("sb",     enc_i(OP_SB),     st | fld(CF_SIZE, SIZE_B));
        add_entry("sh",     enc_i(OP_SH),     st | fld(CF_SIZE, SIZE_H));
        add_entry("sw",     enc_i(OP_SW),     st | fld(CF_SIZE, SIZE_W));
        // Dropped groups decode as reserved
        add_entry("mult",       enc_r(6'b011000), fld(CF_RESERVED, 1));
        add_entry("mfc0",       enc_i(6'b010000), fld(CF_RESERVED, 1));
        add_entry("syscall",    enc_r(6'b001100), fld(CF_RESERVED, 1));
        add_entry("regimm_bad", enc_ri(5'b00010), fld(CF_RESERVED, 1));
    endtask

    task automatic check_ctrl(input string name, input logic [CTRL_W-1:0] exp,
                              input logic [CTRL_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0)
        begin
            $display("PASS %s", name);
            pass_count++;
        end
        else
        begin
            $display("FAIL %s", name);
            fail_count++;
        end
        test_errs = 0;
    endtask

    task automatic apply_entry(input int i);
        dinstr = tinstr[i];
        {cmp_equal, cmp_g0, cmp_e0} = tflags[i];
    endtask

    initial
    begin
        seed = 32'hd175;
        rst_n = 1'b0;
        dinstr = '0;
        flush = '0;
        stall = '0;
        {cmp_equal, cmp_g0, cmp_e0} = 3'b000;
        build_table();
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        #1;
        check_ctrl("reset_e", '0, e_ctrl);
        check_ctrl("reset_m", '0, m_ctrl);
        check_ctrl("reset_w", '0, w_ctrl);
        close_test("reset");

        for (int i = 0; i < n_entries; i++)
        begin
            @(posedge clk);
            #2 apply_entry(i);
            #5;
            check_ctrl(tname[i], tctrl[i], d_ctrl);
            check_bit({tname[i], "_pcsrc"}, tpc[i], pcsrc);
            close_test(tname[i]);
        end

        // Back-to-back words checked one, two and three cycles later
        for (int i = 0; i < 8; i++)
        begin
            @(posedge clk);
            #2 apply_entry(i);
            #5;
            if (i >= 1)
                check_ctrl({"pipe_e_", tname[i-1]}, tctrl[i-1], e_ctrl);
            if (i >= 2)
                check_ctrl({"pipe_m_", tname[i-2]}, tctrl[i-2], m_ctrl);
            if (i >= 3)
                check_ctrl({"pipe_w_", tname[i-3]}, tctrl[i-3], w_ctrl);
        end
        close_test("pipeline");

        @(posedge clk);
        #2 apply_entry(0);
        @(posedge clk);
        #2 apply_entry(1);
        stall = 3'b001;
        @(posedge clk);
        #2 check_ctrl("stall_e_1", tctrl[0], e_ctrl);
        @(posedge clk);
        #2 check_ctrl("stall_e_2", tctrl[0], e_ctrl);
        check_ctrl("stall_m_drain", tctrl[0], m_ctrl); // M kept loading during the stall
        stall = '0;
        @(posedge clk);
        #2 check_ctrl("stall_e_release", tctrl[1], e_ctrl);
        close_test("stall_e");
        flush = 3'b100;
        stall = 3'b100;
        @(posedge clk);
        #2 check_ctrl("flush_stall_w", '0, w_ctrl);
        close_test("flush_stall_w");
        stall = '0;
        flush = 3'b010;
        @(posedge clk);
        #2 check_ctrl("flush_m", '0, m_ctrl);
        check_ctrl("flush_w_drain", tctrl[1], w_ctrl);
        close_test("flush_m");
        flush = '0;

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/mips_isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/branch_resolver.sv
hdl/ctrl_stage_reg.sv
hdl/controller.sv
tests/controller_tb.sv

// File: Bender.yml
package:
  name: mips_decode_ctrl

sources:
  - hdl/mips_isa_pkg.sv
  - hdl/ctrl_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/branch_resolver.sv
  - hdl/ctrl_stage_reg.sv
  - hdl/controller.sv
  - target: simulation
    files:
      - tests/controller_tb.sv
